// ==== include/display_defs.svh ====
// display engine timing constants
// UART bit time, scan geometry and frame memory base address
`ifndef DISPLAY_DEFS_SVH
`define DISPLAY_DEFS_SVH

// clock cycles per serial bit at 8N1
`define CLKS_PER_BIT 8

// horizontal geometry in clocks, 48 per line
`define H_SYNC   4
`define H_BACK   4
`define H_ACTIVE 32
`define H_FRONT  8

// vertical geometry in lines, 8 per frame
`define V_SYNC   1
`define V_BACK   1
`define V_ACTIVE 4
`define V_FRONT  2

// first word of the frame memory
`define FB_BASE 32'h3000_0000

`endif

// ==== source/display_pkg.sv ====
// display engine shared types
// bus widths, received byte and FSM state encodings
`default_nettype none

package display_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [3:0]  sel_t;
    typedef logic [7:0]  rx_byte_t;

    typedef enum logic [1:0] {rx_idle, rx_start, rx_data, rx_stop} rx_state_t;

    typedef enum logic [1:0] {bus_idle, bus_read_wait, bus_write_wait} bus_state_t;

endpackage

`default_nettype wire

// ==== source/uart_rx.sv ====
// UART receiver, 8N1, LSB first
// samples each bit at its midpoint and strobes rx_valid for one cycle
// when a byte with a good stop bit completes
`timescale 1ns/1ps
`default_nettype none
`include "display_defs.svh"

module uart_rx (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  rx_serial,
    output display_pkg::rx_byte_t rx_byte,
    output logic                  rx_valid
);
    import display_pkg::*;

    localparam int CNT_W = $clog2(`CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] HALF_BIT = CNT_W'(`CLKS_PER_BIT / 2 - 1);
    localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(`CLKS_PER_BIT - 1);

    rx_state_t        state;
    logic             rx_meta;
    logic             rx_sync;
    logic [CNT_W-1:0] cnt;
    logic [2:0]       bit_idx;

    always_ff @(posedge clk) begin
        if (rst) begin
            // line idles high
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            state   <= rx_idle;
            cnt     <= '0;
            bit_idx <= '0;
        end else begin
            // two-flop synchronizer on the pin
            rx_meta <= rx_serial;
            rx_sync <= rx_meta;
            case (state)
                rx_idle: begin
                    cnt     <= '0;
                    bit_idx <= '0;
                    // low level after idle high marks the start edge
                    if (!rx_sync) begin
                        state <= rx_start;
                    end
                end
                rx_start: begin
                    if (cnt == HALF_BIT) begin
                        cnt <= '0;
                        // glitch if the line is high again at mid start bit
                        state <= rx_sync ? rx_idle : rx_data;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                rx_data: begin
                    if (cnt == FULL_BIT) begin
                        cnt     <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= rx_stop;
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                rx_stop: begin
                    if (cnt == FULL_BIT) begin
                        cnt   <= '0;
                        state <= rx_idle;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: state <= rx_idle;
            endcase
        end
    end

    // data bits enter from the top, bit 0 ends up in rx_byte[0]
    always_ff @(posedge clk) begin
        if (state == rx_data && cnt == FULL_BIT) begin
            rx_byte <= {rx_sync, rx_byte[7:1]};
        end
    end

    // strobe on the stop bit midpoint, bad stop bit gives no strobe
    assign rx_valid = (state == rx_stop) && (cnt == FULL_BIT) && rx_sync;

endmodule

`default_nettype wire

// ==== source/word_packer.sv ====
// byte to word packer for frame memory writes
// four bytes per word, first byte in bits 7:0, one word buffered
// behind a pending write request
`timescale 1ns/1ps
`default_nettype none
`include "display_defs.svh"

module word_packer (
    input  logic                  clk,
    input  logic                  rst,
    input  display_pkg::rx_byte_t rx_byte,
    input  logic                  rx_valid,
    output logic                  wr_req,
    output display_pkg::addr_t    wr_adr,
    output display_pkg::word_t    wr_dat,
    input  logic                  wr_done
);
    import display_pkg::*;

    localparam int PTR_W = $clog2(`V_ACTIVE);

    word_t            asm_word;
    logic [1:0]       byte_cnt;
    logic             asm_full;
    logic [PTR_W-1:0] word_ptr;

    always_ff @(posedge clk) begin
        if (rst) begin
            byte_cnt <= '0;
            asm_full <= 1'b0;
            wr_req   <= 1'b0;
            word_ptr <= '0;
        end else begin
            // bytes arriving while the buffer is full are dropped
            if (rx_valid && !asm_full) begin
                byte_cnt <= byte_cnt + 1'b1;
                if (byte_cnt == 2'd3) begin
                    asm_full <= 1'b1;
                end
            end
            // hand the word over once the request slot is free
            if (asm_full && !wr_req) begin
                wr_req   <= 1'b1;
                asm_full <= 1'b0;
            end
            if (wr_done) begin
                wr_req   <= 1'b0;
                // wraps after one frame worth of lines
                word_ptr <= (word_ptr == PTR_W'(`V_ACTIVE - 1)) ? '0 : word_ptr + 1'b1;
            end
        end
    end

    // payload path
    always_ff @(posedge clk) begin
        if (rx_valid && !asm_full) begin
            asm_word <= {rx_byte, asm_word[31:8]};
        end
        if (asm_full && !wr_req) begin
            wr_dat <= asm_word;
        end
    end

    // pointer only moves on wr_done so the address holds with the request
    assign wr_adr = addr_t'(`FB_BASE) + addr_t'({word_ptr, 2'b00});

endmodule

`default_nettype wire

// ==== source/scan_timing.sv ====
// scan timing generator
// line and frame counters with sync, line start and active window decode
`timescale 1ns/1ps
`default_nettype none
`include "display_defs.svh"

module scan_timing (
    input  logic       clk,
    input  logic       rst,
    output logic       h_sync,
    output logic       v_sync,
    output logic       line_start,
    output logic       pixel_active,
    output logic [1:0] line_index
);

    localparam int H_TOTAL = `H_SYNC + `H_BACK + `H_ACTIVE + `H_FRONT;
    localparam int V_TOTAL = `V_SYNC + `V_BACK + `V_ACTIVE + `V_FRONT;
    localparam int H_W     = $clog2(H_TOTAL);
    localparam int V_W     = $clog2(V_TOTAL);
    // first active column and first visible line
    localparam int H_LEFT  = `H_SYNC + `H_BACK;
    localparam int V_TOP   = `V_SYNC + `V_BACK;

    logic [H_W-1:0] h_cnt;
    logic [V_W-1:0] v_cnt;
    logic [H_W-1:0] h_next;
    logic [V_W-1:0] v_next;
    logic           v_visible;

    // next counter values, vertical steps at end of line
    always_comb begin
        h_next = (h_cnt == H_W'(H_TOTAL - 1)) ? '0 : h_cnt + 1'b1;
        v_next = v_cnt;
        if (h_cnt == H_W'(H_TOTAL - 1)) begin
            v_next = (v_cnt == V_W'(V_TOTAL - 1)) ? '0 : v_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            h_cnt  <= '0;
            v_cnt  <= '0;
            // sync idles high
            h_sync <= 1'b1;
            v_sync <= 1'b1;
        end else begin
            h_cnt  <= h_next;
            v_cnt  <= v_next;
            // decoded from the next count to stay aligned with the counters
            h_sync <= (h_next >= H_W'(`H_SYNC));
            v_sync <= (v_next >= V_W'(`V_SYNC));
        end
    end

    assign v_visible    = (v_cnt >= V_W'(V_TOP)) && (v_cnt < V_W'(V_TOP + `V_ACTIVE));
    assign line_start   = v_visible && (h_cnt == '0);
    assign pixel_active = v_visible && (h_cnt >= H_W'(H_LEFT))
                          && (h_cnt < H_W'(H_LEFT + `H_ACTIVE));
    assign line_index   = 2'(v_cnt - V_W'(V_TOP));

endmodule

`default_nettype wire

// ==== source/line_fetch.sv ====
// per-line fetcher
// reads one word per visible line and shifts it out LSB first,
// a line whose data misses the active window shows black
`timescale 1ns/1ps
`default_nettype none
`include "display_defs.svh"

module line_fetch (
    input  logic               clk,
    input  logic               rst,
    input  logic               line_start,
    input  logic               pixel_active,
    input  logic [1:0]         line_index,
    output logic               rd_req,
    output display_pkg::addr_t rd_adr,
    input  display_pkg::word_t rd_dat,
    input  logic               rd_done,
    output logic               pixel_data
);
    import display_pkg::*;

    word_t pix_shift;
    logic  line_valid;
    logic  seen_active;

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_req      <= 1'b0;
            line_valid  <= 1'b0;
            seen_active <= 1'b0;
        end else begin
            if (pixel_active) begin
                seen_active <= 1'b1;
            end
            if (line_start) begin
                line_valid <= 1'b0;
                // a read still pending from the last line keeps its address
                // and seen_active stays set so its data is discarded
                if (!rd_req) begin
                    rd_req      <= 1'b1;
                    seen_active <= 1'b0;
                end
            end
            if (rd_done) begin
                rd_req <= 1'b0;
                // late data counts as a missed line
                if (!seen_active && !pixel_active) begin
                    line_valid <= 1'b1;
                end
            end
        end
    end

    // address and pixel payload
    always_ff @(posedge clk) begin
        if (line_start && !rd_req) begin
            rd_adr <= addr_t'(`FB_BASE) + addr_t'({line_index, 2'b00});
        end
        if (rd_done && !seen_active && !pixel_active) begin
            pix_shift <= rd_dat;
        end else if (pixel_active) begin
            pix_shift <= {1'b0, pix_shift[31:1]};
        end
    end

    assign pixel_data = pixel_active && line_valid && pix_shift[0];

endmodule

`default_nettype wire

// ==== source/wb_bus_master.sv ====
// Wishbone classic master for the display engine
// serves a read client and a write client, read first when both wait,
// one single-beat cycle at a time with an idle cycle in between
`timescale 1ns/1ps
`default_nettype none

module wb_bus_master (
    input  logic               clk,
    input  logic               rst,
    // read client
    input  logic               rd_req,
    input  display_pkg::addr_t rd_adr,
    output display_pkg::word_t rd_dat,
    output logic               rd_done,
    // write client
    input  logic               wr_req,
    input  display_pkg::addr_t wr_adr,
    input  display_pkg::word_t wr_dat,
    output logic               wr_done,
    // Wishbone
    output display_pkg::addr_t ADR_O,
    output display_pkg::word_t DAT_O,
    output display_pkg::sel_t  SEL_O,
    output logic               WE_O,
    output logic               STB_O,
    output logic               CYC_O,
    input  display_pkg::word_t DAT_I,
    input  logic               ACK_I
);
    import display_pkg::*;

    bus_state_t state;
    logic       cyc_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= bus_idle;
            cyc_q <= 1'b0;
            WE_O  <= 1'b0;
        end else begin
            case (state)
                bus_idle: begin
                    // read side wins so line data arrives in time
                    if (rd_req) begin
                        cyc_q <= 1'b1;
                        WE_O  <= 1'b0;
                        state <= bus_read_wait;
                    end else if (wr_req) begin
                        cyc_q <= 1'b1;
                        WE_O  <= 1'b1;
                        state <= bus_write_wait;
                    end
                end
                bus_read_wait, bus_write_wait: begin
                    // hold everything until the slave acks
                    if (ACK_I) begin
                        cyc_q <= 1'b0;
                        WE_O  <= 1'b0;
                        state <= bus_idle;
                    end
                end
                default: state <= bus_idle;
            endcase
        end
    end

    // address and data latched only when a cycle starts
    always_ff @(posedge clk) begin
        if (state == bus_idle) begin
            if (rd_req) begin
                ADR_O <= rd_adr;
            end else if (wr_req) begin
                ADR_O <= wr_adr;
                DAT_O <= wr_dat;
            end
        end
    end

    // full words only
    assign SEL_O = sel_t'('1);
    assign CYC_O = cyc_q;
    assign STB_O = cyc_q;

    // done pulses in the ack cycle, client captures read data there
    assign rd_done = (state == bus_read_wait) && ACK_I;
    assign wr_done = (state == bus_write_wait) && ACK_I;
    assign rd_dat  = DAT_I;

endmodule

`default_nettype wire

// ==== source/display_core.sv ====
// display engine core
// UART in, word packing, scan timing, line fetch and one Wishbone master
`timescale 1ns/1ps
`default_nettype none

module display_core (
    input  logic               clk,
    input  logic               rst,
    input  logic               rx_serial,
    output logic               h_out,
    output logic               v_out,
    output logic               pixel_data,
    output display_pkg::addr_t ADR_O,
    output display_pkg::word_t DAT_O,
    output display_pkg::sel_t  SEL_O,
    output logic               WE_O,
    output logic               STB_O,
    output logic               CYC_O,
    input  display_pkg::word_t DAT_I,
    input  logic               ACK_I
);
    import display_pkg::*;

    // receiver to packer
    rx_byte_t   rx_byte;
    logic       rx_valid;
    // write client
    logic       wr_req;
    addr_t      wr_adr;
    word_t      wr_dat;
    logic       wr_done;
    // read client
    logic       rd_req;
    addr_t      rd_adr;
    word_t      rd_dat;
    logic       rd_done;
    // timing to fetcher
    logic       line_start;
    logic       pixel_active;
    logic [1:0] line_index;

    uart_rx u_uart_rx (
        .clk      (clk),
        .rst      (rst),
        .rx_serial(rx_serial),
        .rx_byte  (rx_byte),
        .rx_valid (rx_valid)
    );

    word_packer u_word_packer (
        .clk     (clk),
        .rst     (rst),
        .rx_byte (rx_byte),
        .rx_valid(rx_valid),
        .wr_req  (wr_req),
        .wr_adr  (wr_adr),
        .wr_dat  (wr_dat),
        .wr_done (wr_done)
    );

    // sync levels leave the core directly
    scan_timing u_scan_timing (
        .clk         (clk),
        .rst         (rst),
        .h_sync      (h_out),
        .v_sync      (v_out),
        .line_start  (line_start),
        .pixel_active(pixel_active),
        .line_index  (line_index)
    );

    line_fetch u_line_fetch (
        .clk         (clk),
        .rst         (rst),
        .line_start  (line_start),
        .pixel_active(pixel_active),
        .line_index  (line_index),
        .rd_req      (rd_req),
        .rd_adr      (rd_adr),
        .rd_dat      (rd_dat),
        .rd_done     (rd_done),
        .pixel_data  (pixel_data)
    );

    wb_bus_master u_wb_bus_master (
        .clk    (clk),
        .rst    (rst),
        .rd_req (rd_req),
        .rd_adr (rd_adr),
        .rd_dat (rd_dat),
        .rd_done(rd_done),
        .wr_req (wr_req),
        .wr_adr (wr_adr),
        .wr_dat (wr_dat),
        .wr_done(wr_done),
        .ADR_O  (ADR_O),
        .DAT_O  (DAT_O),
        .SEL_O  (SEL_O),
        .WE_O   (WE_O),
        .STB_O  (STB_O),
        .CYC_O  (CYC_O),
        .DAT_I  (DAT_I),
        .ACK_I  (ACK_I)
    );

endmodule

`default_nettype wire

// ==== source/chip_top.sv ====
// chip-level user block in the harness pin frame
// serial in on gpio 5, sync and pixel out on gpio 2:0 while enabled
`timescale 1ns/1ps
`default_nettype none

module chip_top (
    input  logic        clk,
    input  logic        rst,
    input  logic        en,
    input  logic [33:0] gpio_in,
    output logic [33:0] gpio_out,
    output logic [33:0] gpio_oeb,
    output logic [31:0] ADR_O,
    output logic [31:0] DAT_O,
    output logic [3:0]  SEL_O,
    output logic        WE_O,
    output logic        STB_O,
    output logic        CYC_O,
    input  logic [31:0] DAT_I,
    input  logic        ACK_I
);

    logic h_out;
    logic v_out;
    logic pixel_data;

    // core keeps running whatever en does
    display_core u_display_core (
        .clk       (clk),
        .rst       (rst),
        .rx_serial (gpio_in[5]),
        .h_out     (h_out),
        .v_out     (v_out),
        .pixel_data(pixel_data),
        .ADR_O     (ADR_O),
        .DAT_O     (DAT_O),
        .SEL_O     (SEL_O),
        .WE_O      (WE_O),
        .STB_O     (STB_O),
        .CYC_O     (CYC_O),
        .DAT_I     (DAT_I),
        .ACK_I     (ACK_I)
    );

    // pad gating, oeb is active low
    // unused pins stay inputs driven to 0
    always_comb begin
        gpio_out = '0;
        gpio_oeb = '1;
        if (en) begin
            gpio_out[0]   = h_out;
            gpio_out[1]   = v_out;
            gpio_out[2]   = pixel_data;
            gpio_oeb[2:0] = 3'b000;
        end
    end

endmodule

`default_nettype wire

// ==== verif/chip_top_tb.sv ====
// testbench for the display engine chip block
// UART byte driver, Wishbone slave memory with random ACK delays,
// scan position model for sync and pixel checks, pin gating and watchdog
`timescale 1ns/1ps
`default_nettype none
`include "display_defs.svh"

module chip_top_tb;
    import display_pkg::*;

    localparam int CLK_PERIOD    = 4;
    localparam int H_TOTAL       = `H_SYNC + `H_BACK + `H_ACTIVE + `H_FRONT;
    localparam int V_TOTAL       = `V_SYNC + `V_BACK + `V_ACTIVE + `V_FRONT;
    localparam int H_LEFT        = `H_SYNC + `H_BACK;
    localparam int V_TOP         = `V_SYNC + `V_BACK;
    localparam int FRAME_CYCLES  = H_TOTAL * V_TOTAL;
    localparam int BYTE_CYCLES   = 10 * `CLKS_PER_BIT;
    localparam int NUM_BYTES     = 4 * `V_ACTIVE;
    // ack held this long lands well inside the active window
    localparam int STALL_CYCLES  = 20;
    localparam int STALL_LINE    = 2;
    localparam int EN_LOW_CYCLES = 100;
    // serial time, three checked frames, four frames for alignment and en low
    localparam int WATCHDOG_NS   = (NUM_BYTES * BYTE_CYCLES + 7 * FRAME_CYCLES) * CLK_PERIOD;

    logic        clk;
    logic        rst;
    logic        en;
    logic [33:0] gpio_in;
    logic [33:0] gpio_out;
    logic [33:0] gpio_oeb;
    addr_t       ADR_O;
    word_t       DAT_O;
    sel_t        SEL_O;
    logic        WE_O;
    logic        STB_O;
    logic        CYC_O;
    word_t       DAT_I;
    logic        ACK_I;

    // stimulus table, one word per visible line
    word_t       line_words [4];
    // slave memory, one word per line
    word_t       mem [4];
    logic [3:0]  line_ok;
    logic        check_pixels;
    logic        stall_armed;
    logic [15:0] lfsr;
    int          slave_delay;
    logic [1:0]  slave_idx;
    // scan position model
    int          mh;
    int          mv;
    // bus monitor state
    int          write_count;
    int          read_count;
    int          exp_line;
    logic        in_cycle;
    logic        ack_prev;
    addr_t       held_adr;
    word_t       held_dat;
    logic        held_we;
    logic        exp_h;
    logic        exp_v;
    logic        exp_p;

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    chip_top DUT (
        .clk     (clk),
        .rst     (rst),
        .en      (en),
        .gpio_in (gpio_in),
        .gpio_out(gpio_out),
        .gpio_oeb(gpio_oeb),
        .ADR_O   (ADR_O),
        .DAT_O   (DAT_O),
        .SEL_O   (SEL_O),
        .WE_O    (WE_O),
        .STB_O   (STB_O),
        .CYC_O   (CYC_O),
        .DAT_I   (DAT_I),
        .ACK_I   (ACK_I)
    );

    // 16-bit Galois LFSR, taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // two LFSR steps per delay, 0 to 3 cycles
    task automatic next_ack_delay(output int d);
        logic [1:0] b;
        b[0] = lfsr[0];
        lfsr = lfsr_next(lfsr);
        b[1] = lfsr[0];
        lfsr = lfsr_next(lfsr);
        d = int'(b);
    endtask

    task automatic abort_run();
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic compare(input string name, input logic [33:0] got, input logic [33:0] exp);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    // one serial bit, called right after a rising edge
    task automatic serial_bit(input logic b);
        gpio_in[5] <= b;
        repeat (`CLKS_PER_BIT) @(posedge clk);
    endtask

    // 8N1, bit 0 first
    task automatic send_byte(input logic [7:0] data);
        int i;
        serial_bit(1'b0);
        for (i = 0; i < 8; i++) begin
            serial_bit(data[i]);
        end
        serial_bit(1'b1);
    endtask

    // returns at the falling edge of horizontal count 0, frame line 0
    task automatic wait_frame_start();
        do begin
            @(negedge clk);
        end while (!(mh == 0 && mv == 0));
    endtask

    // expected scan position, counting from 0 after reset
    always @(posedge clk) begin
        if (rst) begin
            mh <= 0;
            mv <= 0;
        end else if (mh == H_TOTAL - 1) begin
            mh <= 0;
            mv <= (mv == V_TOTAL - 1) ? 0 : mv + 1;
        end else begin
            mh <= mh + 1;
        end
    end

    // Wishbone slave memory
    always begin
        @(posedge clk);
        if (CYC_O && STB_O) begin
            // one armed read of the stall line gets a late ack
            if (!WE_O && stall_armed && ADR_O == `FB_BASE + 4 * STALL_LINE) begin
                slave_delay = STALL_CYCLES;
                stall_armed <= 1'b0;
            end else begin
                next_ack_delay(slave_delay);
            end
            repeat (slave_delay) @(posedge clk);
            slave_idx = ADR_O[3:2];
            if (WE_O) begin
                mem[slave_idx] <= DAT_O;
            end
            DAT_I <= mem[slave_idx];
            ACK_I <= 1'b1;
            @(posedge clk);
            ACK_I <= 1'b0;
        end
    end

    // bus monitor, write contents, read order and hold until ACK
    always @(negedge clk) begin
        compare("STB_O", STB_O, CYC_O);
        // master drops the cycle after ACK and idles one cycle
        if (ack_prev) begin
            compare("CYC_O after ACK", CYC_O, 1'b0);
        end
        if (!CYC_O && in_cycle) begin
            $display("bus cycle dropped before ACK at %0t ns", $time);
            abort_run();
        end
        if (CYC_O && !in_cycle) begin
            in_cycle = 1'b1;
            held_adr = ADR_O;
            held_dat = DAT_O;
            held_we  = WE_O;
            compare("SEL_O", SEL_O, 4'hF);
            if (WE_O) begin
                if (write_count >= `V_ACTIVE) begin
                    $display("unexpected extra write cycle at %0t ns", $time);
                    abort_run();
                end
                compare("ADR_O", ADR_O, `FB_BASE + 4 * write_count);
                compare("DAT_O", DAT_O, line_words[write_count]);
            end else begin
                if (mv < V_TOP || mv >= V_TOP + `V_ACTIVE) begin
                    $display("read cycle outside a visible line at %0t ns", $time);
                    abort_run();
                end
                compare("read line index", exp_line, mv - V_TOP);
                compare("ADR_O", ADR_O, `FB_BASE + 4 * exp_line);
            end
        end else if (CYC_O) begin
            compare("ADR_O", ADR_O, held_adr);
            compare("WE_O", WE_O, held_we);
            compare("SEL_O", SEL_O, 4'hF);
            if (held_we) begin
                compare("DAT_O", DAT_O, held_dat);
            end
        end
        if (CYC_O && ACK_I) begin
            in_cycle = 1'b0;
            if (held_we) begin
                write_count++;
            end else begin
                read_count++;
                exp_line = (exp_line + 1) % `V_ACTIVE;
            end
        end
        ack_prev = CYC_O && ACK_I;
    end

    // pad checks, gated pins or sync and pixel output
    always @(negedge clk) begin
        if (!en) begin
            compare("gpio_out", gpio_out, 34'd0);
            compare("gpio_oeb", gpio_oeb, {34{1'b1}});
        end else if (check_pixels) begin
            exp_h = (mh >= `H_SYNC);
            exp_v = (mv >= `V_SYNC);
            exp_p = 1'b0;
            if (mv >= V_TOP && mv < V_TOP + `V_ACTIVE
                && mh >= H_LEFT && mh < H_LEFT + `H_ACTIVE) begin
                // pixel x of line n is bit x of word n
                exp_p = line_ok[mv - V_TOP] & line_words[mv - V_TOP][mh - H_LEFT];
            end
            compare("h_out", gpio_out[0], exp_h);
            compare("v_out", gpio_out[1], exp_v);
            compare("pixel_data", gpio_out[2], exp_p);
            compare("gpio_out[33:3]", gpio_out[33:3], 34'd0);
            compare("gpio_oeb", gpio_oeb, {{31{1'b1}}, 3'b000});
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog timeout, test sequence did not complete");
        abort_run();
    end

    initial begin
        int i;
        int w;
        int b;
        line_words[0] = 32'h5555_5555;
        line_words[1] = 32'h8000_0001;
        line_words[2] = 32'h0F0F_F0F0;
        line_words[3] = 32'h0001_0000;
        // fill from the full address so stale reads stand out
        for (i = 0; i < 4; i++) begin
            mem[i] = ~(`FB_BASE + 4 * i);
        end
        lfsr         = 16'd87;
        line_ok      = 4'hF;
        check_pixels = 1'b0;
        stall_armed  = 1'b0;
        write_count  = 0;
        read_count   = 0;
        exp_line     = 0;
        in_cycle     = 1'b0;
        ack_prev     = 1'b0;
        rst          = 1'b1;
        en           = 1'b0;
        gpio_in      = '0;
        // serial line idles high
        gpio_in[5]   = 1'b1;
        DAT_I        = '0;
        ACK_I        = 1'b0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        compare("CYC_O", CYC_O, 1'b0);
        compare("STB_O", STB_O, 1'b0);
        compare("WE_O", WE_O, 1'b0);
        @(posedge clk);
        en <= 1'b1;
        // table out over UART, low byte first
        for (w = 0; w < `V_ACTIVE; w++) begin
            for (b = 0; b < 4; b++) begin
                send_byte(line_words[w][8 * b +: 8]);
            end
        end
        wait (write_count == `V_ACTIVE);
        // full frame with every line fetched in time
        wait_frame_start();
        check_pixels <= 1'b1;
        repeat (FRAME_CYCLES) @(negedge clk);
        // next frame, stall line ack past the active start
        line_ok[STALL_LINE] <= 1'b0;
        stall_armed         <= 1'b1;
        repeat (FRAME_CYCLES) @(negedge clk);
        line_ok[STALL_LINE] <= 1'b1;
        // pins gated off while the core keeps scanning
        @(posedge clk);
        en <= 1'b0;
        repeat (EN_LOW_CYCLES) @(posedge clk);
        en <= 1'b1;
        wait_frame_start();
        repeat (FRAME_CYCLES) @(negedge clk);
        if (write_count != `V_ACTIVE || read_count < 3 * `V_ACTIVE) begin
            $display("bus traffic incomplete, %0d writes and %0d reads seen",
                     write_count, read_count);
            abort_run();
        end else begin
            $display("RESULT: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+include
source/display_pkg.sv
source/uart_rx.sv
source/word_packer.sv
source/scan_timing.sv
source/line_fetch.sv
source/wb_bus_master.sv
source/display_core.sv
source/chip_top.sv
verif/chip_top_tb.sv

// ==== Bender.yml ====
package:
  name: chip_display

export_include_dirs:
  - include

sources:
  - files:
      - source/display_pkg.sv
      - source/uart_rx.sv
      - source/word_packer.sv
      - source/scan_timing.sv
      - source/line_fetch.sv
      - source/wb_bus_master.sv
      - source/display_core.sv
      - source/chip_top.sv
  - target: test
    files:
      - verif/chip_top_tb.sv
